// File: common/cpu_pkg.sv
package cpu_pkg;

   // datapath and register file sizes
   localparam int word_w = 32;
   localparam int reg_addr_w = 4;
   localparam int flags_w = 4;

   localparam int pc_idx = 15;   // r15 is the program counter
   localparam int link_idx = 14; // call return address lands here

   // bit positions inside the flag word
   localparam int flag_z = 0;
   localparam int flag_c = 1;
   localparam int flag_n = 2;
   localparam int flag_v = 3;

   typedef enum logic [1:0] {
      ph_fetch,
      ph_exec,
      ph_mem,
      ph_wb
   } phase_t;

   // code bits 27:25, unlisted values act as no-ops
   typedef enum logic [2:0] {
      cls_alu_reg = 3'd0,
      cls_alu_imm = 3'd1,
      cls_call    = 3'd2,
      cls_st      = 3'd4,
      cls_ld      = 3'd5
   } inst_class_t;

   typedef enum logic [3:0] {
      op_add, op_sub, op_and, op_or, op_xor,
      op_mov, op_shl, op_shr, op_cmp
   } alu_op_t;

   // 0 and 15 both execute unconditionally
   typedef enum logic [3:0] {
      c_al = 4'd0, c_eq, c_ne, c_cs, c_cc, c_mi, c_pl, c_vs,
      c_vc, c_hi, c_ls, c_ge, c_lt, c_gt, c_le, c_nv2 = 4'd15
   } cond_t;

endpackage

// File: hdl/phase_sched.sv
`timescale 1ns/1ps

module phase_sched (
   input  logic              clk,
   input  logic              rst_i,
   output cpu_pkg::phase_t   phase_o
);

   cpu_pkg::phase_t phase_nxt;

   // one phase per clock, wb wraps to fetch
   always_comb
   begin
      case (phase_o)
         cpu_pkg::ph_fetch: phase_nxt = cpu_pkg::ph_exec;
         cpu_pkg::ph_exec:  phase_nxt = cpu_pkg::ph_mem;
         cpu_pkg::ph_mem:   phase_nxt = cpu_pkg::ph_wb;
         default:           phase_nxt = cpu_pkg::ph_fetch;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
         phase_o <= cpu_pkg::ph_fetch;
      else
         phase_o <= phase_nxt;
   end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
   input  logic                            clk,
   input  logic                            rst_i,
   input  logic [cpu_pkg::reg_addr_w-1:0]  ra_i,
   input  logic [cpu_pkg::reg_addr_w-1:0]  rb_i,
   input  logic [cpu_pkg::reg_addr_w-1:0]  rd_i,
   input  logic [cpu_pkg::reg_addr_w-1:0]  rt_i,
   input  logic [cpu_pkg::reg_addr_w-1:0]  wr_addr_i,
   input  logic [cpu_pkg::word_w-1:0]      wr_data_i,
   input  logic                            wr_en_i,
   input  logic                            link_en_i,
   input  logic                            pc_inc_i,
   output logic [cpu_pkg::word_w-1:0]      da_o,
   output logic [cpu_pkg::word_w-1:0]      db_o,
   output logic [cpu_pkg::word_w-1:0]      dd_o,
   output logic [cpu_pkg::word_w-1:0]      dt_o,
   output logic [cpu_pkg::word_w-1:0]      pc_o
);

   logic [cpu_pkg::word_w-1:0] regs [2**cpu_pkg::reg_addr_w];

   // combinational reads
   assign da_o = regs[ra_i];
   assign db_o = regs[rb_i];
   assign dd_o = regs[rd_i];
   assign dt_o = regs[rt_i]; // test port
   assign pc_o = regs[cpu_pkg::pc_idx];

   // later statements win, so a write to r15 beats the increment
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (pc_inc_i)
            regs[cpu_pkg::pc_idx] <= regs[cpu_pkg::pc_idx] + 1'b1;
         if (link_en_i)
            regs[cpu_pkg::link_idx] <= regs[cpu_pkg::pc_idx]; // pc already advanced
         if (wr_en_i)
            regs[wr_addr_i] <= wr_data_i;
      end
   end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
   input  cpu_pkg::alu_op_t                op_i,
   input  logic [cpu_pkg::word_w-1:0]      a_i,
   input  logic [cpu_pkg::word_w-1:0]      b_i,
   input  logic [cpu_pkg::flags_w-1:0]     flags_i,
   output logic [cpu_pkg::word_w-1:0]      res_o,
   output logic [cpu_pkg::flags_w-1:0]     flags_o,
   output logic                            wb_en_o,
   output logic                            flag_en_o
);

   localparam int msb = cpu_pkg::word_w - 1;

   logic              sub_op;
   logic [msb:0]      b_add;
   logic [msb+1:0]    sum;   // top bit is carry out
   logic [4:0]        shamt;

   // sub and cmp add the inverted operand plus one
   assign sub_op = (op_i == cpu_pkg::op_sub) || (op_i == cpu_pkg::op_cmp);
   assign b_add = sub_op ? ~b_i : b_i;
   assign sum = {1'b0, a_i} + {1'b0, b_add} + {{cpu_pkg::word_w{1'b0}}, sub_op};
   assign shamt = b_i[4:0];

   always_comb
   begin
      res_o = '0;
      flags_o = flags_i; // c and v kept unless arithmetic
      wb_en_o = 1'b1;
      flag_en_o = 1'b1;
      case (op_i)
         cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_cmp:
         begin
            res_o = sum[msb:0];
            flags_o[cpu_pkg::flag_c] = sum[msb+1]; // set means no borrow on sub
            flags_o[cpu_pkg::flag_v] = (a_i[msb] == b_add[msb]) && (sum[msb] != a_i[msb]);
            wb_en_o = (op_i != cpu_pkg::op_cmp);
         end
         cpu_pkg::op_and:
            res_o = a_i & b_i;
         cpu_pkg::op_or:
            res_o = a_i | b_i;
         cpu_pkg::op_xor:
            res_o = a_i ^ b_i;
         cpu_pkg::op_shl:
            res_o = a_i << shamt;
         cpu_pkg::op_shr:
            res_o = a_i >> shamt;
         cpu_pkg::op_mov:
         begin
            res_o = b_i;
            flag_en_o = 1'b0; // plain move leaves flags alone
         end
         default:
         begin
            // undefined opcode does nothing
            wb_en_o = 1'b0;
            flag_en_o = 1'b0;
         end
      endcase
      flags_o[cpu_pkg::flag_z] = (res_o == '0);
      flags_o[cpu_pkg::flag_n] = res_o[msb];
   end

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
   input  logic                            clk,
   input  logic                            rst_i,
   output logic [cpu_pkg::word_w-1:0]      mem_addr_o,
   input  logic [cpu_pkg::word_w-1:0]      mem_rdata_i,
   output logic [cpu_pkg::word_w-1:0]      mem_wdata_o,
   output logic                            mem_we_o,
   input  logic [cpu_pkg::reg_addr_w-1:0]  test_rsel_i,
   output logic [cpu_pkg::word_w-1:0]      test_reg_o
);

   localparam int w = cpu_pkg::word_w;

   cpu_pkg::phase_t             phase;
   logic                        phf, phe, phm, phw;
   logic [w-1:0]                ir;      // instruction register
   logic [cpu_pkg::flags_w-1:0] flags;
   logic [w-1:0]                ld_data; // word read by a load

   // instruction fields
   cpu_pkg::cond_t              cond;
   cpu_pkg::inst_class_t        cls;
   cpu_pkg::alu_op_t            alu_op;
   logic [cpu_pkg::reg_addr_w-1:0] rd, ra, rb;
   logic                        is_alu, is_ld, is_st, is_call;
   logic                        ena;     // condition passed

   logic [w-1:0]                da, db, dd, pc;
   logic [w-1:0]                alu_b, alu_res;
   logic [cpu_pkg::flags_w-1:0] alu_flags;
   logic                        alu_wb_en, alu_flag_en;
   logic [w-1:0]                imm12, off16, ldst_addr, call_tgt;
   logic [w-1:0]                wb_data;
   logic [cpu_pkg::reg_addr_w-1:0] wb_addr;
   logic                        wb_en, flag_wr;
   logic                        f_z, f_c, f_n, f_v;

   phase_sched u_sched (
      .clk     (clk),
      .rst_i   (rst_i),
      .phase_o (phase)
   );

   assign phf = (phase == cpu_pkg::ph_fetch);
   assign phe = (phase == cpu_pkg::ph_exec);
   assign phm = (phase == cpu_pkg::ph_mem);
   assign phw = (phase == cpu_pkg::ph_wb);

   always_ff @(posedge clk)
   begin
      if (rst_i)
         ir <= '0;
      else if (phf)
         ir <= mem_rdata_i;
   end

   assign cond = cpu_pkg::cond_t'(ir[31:28]);
   assign cls = cpu_pkg::inst_class_t'(ir[27:25]);
   assign rd = ir[23:20];
   assign ra = ir[19:16];
   assign alu_op = cpu_pkg::alu_op_t'(ir[15:12]);
   assign rb = ir[11:8];

   assign is_alu = (cls == cpu_pkg::cls_alu_reg) || (cls == cpu_pkg::cls_alu_imm);
   assign is_ld = (cls == cpu_pkg::cls_ld);
   assign is_st = (cls == cpu_pkg::cls_st);
   assign is_call = (cls == cpu_pkg::cls_call);

   assign f_z = flags[cpu_pkg::flag_z];
   assign f_c = flags[cpu_pkg::flag_c];
   assign f_n = flags[cpu_pkg::flag_n];
   assign f_v = flags[cpu_pkg::flag_v];

   always_comb
   begin
      ena = 1'b1; // al and nv2
      case (cond)
         cpu_pkg::c_eq: ena = f_z;
         cpu_pkg::c_ne: ena = !f_z;
         cpu_pkg::c_cs: ena = f_c;
         cpu_pkg::c_cc: ena = !f_c;
         cpu_pkg::c_mi: ena = f_n;
         cpu_pkg::c_pl: ena = !f_n;
         cpu_pkg::c_vs: ena = f_v;
         cpu_pkg::c_vc: ena = !f_v;
         cpu_pkg::c_hi: ena = f_c && !f_z;           // unsigned greater
         cpu_pkg::c_ls: ena = !f_c || f_z;
         cpu_pkg::c_ge: ena = (f_n == f_v);          // signed
         cpu_pkg::c_lt: ena = (f_n != f_v);
         cpu_pkg::c_gt: ena = !f_z && (f_n == f_v);
         cpu_pkg::c_le: ena = f_z || (f_n != f_v);
         default: ena = 1'b1;
      endcase
   end

   reg_file u_regs (
      .clk       (clk),
      .rst_i     (rst_i),
      .ra_i      (ra),
      .rb_i      (rb),
      .rd_i      (rd),
      .rt_i      (test_rsel_i),
      .wr_addr_i (wb_addr),
      .wr_data_i (wb_data),
      .wr_en_i   (wb_en),
      .link_en_i (ena && is_call && phm),
      .pc_inc_i  (phe),
      .da_o      (da),
      .db_o      (db),
      .dd_o      (dd),
      .dt_o      (test_reg_o),
      .pc_o      (pc)
   );

   // sign-extended immediates, zero-extended call target
   assign imm12 = {{(w-12){ir[11]}}, ir[11:0]};
   assign off16 = {{(w-16){ir[15]}}, ir[15:0]};
   assign call_tgt = {{(w-24){1'b0}}, ir[23:0]};
   assign ldst_addr = da + off16;

   assign alu_b = (cls == cpu_pkg::cls_alu_imm) ? imm12 : db;

   alu u_alu (
      .op_i      (alu_op),
      .a_i       (da),
      .b_i       (alu_b),
      .flags_i   (flags),
      .res_o     (alu_res),
      .flags_o   (alu_flags),
      .wb_en_o   (alu_wb_en),
      .flag_en_o (alu_flag_en)
   );

   assign flag_wr = ena && is_alu && alu_flag_en && phw;

   always_ff @(posedge clk)
   begin
      if (rst_i)
         flags <= '0;
      else if (flag_wr)
         flags <= alu_flags;
   end

   always_ff @(posedge clk)
   begin
      if (phm && is_ld)
         ld_data <= mem_rdata_i;
   end

   // write-back select, call always goes to r15
   assign wb_data = is_call ? call_tgt : (is_ld ? ld_data : alu_res);
   assign wb_addr = is_call ? cpu_pkg::reg_addr_w'(cpu_pkg::pc_idx) : rd;
   assign wb_en = ena && phw && ((is_alu && alu_wb_en) || is_ld || is_call);

   // pc everywhere except a taken load/store access
   assign mem_addr_o = (phm && ena && (is_ld || is_st)) ? ldst_addr : pc;
   assign mem_wdata_o = is_st ? db : dd; // rd shown while idle
   assign mem_we_o = ena && is_st && phm;

endmodule

// File: tests/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
   input logic                        clk,
   input logic                        rst_i,
   input cpu_pkg::phase_t             phase_i,
   input logic                        mem_we_i,
   input logic [cpu_pkg::word_w-1:0]  mem_addr_i,
   input logic [cpu_pkg::word_w-1:0]  pc_i
);

   // fetch, exec, mem, wb and round again
   a_fetch_exec: assert property (@(posedge clk) disable iff (rst_i)
      phase_i == cpu_pkg::ph_fetch |=> phase_i == cpu_pkg::ph_exec)
      else $error("phase did not move from fetch to exec");

   a_exec_mem: assert property (@(posedge clk) disable iff (rst_i)
      phase_i == cpu_pkg::ph_exec |=> phase_i == cpu_pkg::ph_mem)
      else $error("phase did not move from exec to mem");

   a_mem_wb: assert property (@(posedge clk) disable iff (rst_i)
      phase_i == cpu_pkg::ph_mem |=> phase_i == cpu_pkg::ph_wb)
      else $error("phase did not move from mem to wb");

   a_wb_fetch: assert property (@(posedge clk) disable iff (rst_i)
      phase_i == cpu_pkg::ph_wb |=> phase_i == cpu_pkg::ph_fetch)
      else $error("phase did not wrap from wb to fetch");

   a_we_mem: assert property (@(posedge clk) disable iff (rst_i)
      mem_we_i |-> phase_i == cpu_pkg::ph_mem)
      else $error("memory write outside the memory phase");

   a_fetch_addr: assert property (@(posedge clk) disable iff (rst_i)
      phase_i == cpu_pkg::ph_fetch |-> mem_addr_i == pc_i)
      else $error("fetch address differs from the program counter");

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

   localparam int instr_total = 37;
   // four cycles per instruction, then snapshot and reset cycles, then slack
   localparam int cycle_limit = instr_total * 4 + 6 * (16 + 3) + 50;

   logic        clk;
   logic        rst;
   logic [31:0] mem_addr;
   logic [31:0] mem_rdata;
   logic [31:0] mem_wdata;
   logic        mem_we;
   logic [3:0]  test_rsel;
   logic [31:0] test_reg;
   logic [31:0] mem [256];
   logic [31:0] image [256]; // loaded into mem while reset is high
   logic [31:0] snap [16];
   int          errors = 0;
   int          cycles = 0;

   cpu_core uut (
      .clk         (clk),
      .rst_i       (rst),
      .mem_addr_o  (mem_addr),
      .mem_rdata_i (mem_rdata),
      .mem_wdata_o (mem_wdata),
      .mem_we_o    (mem_we),
      .test_rsel_i (test_rsel),
      .test_reg_o  (test_reg)
   );

   bind cpu_core cpu_assertions u_asrt (
      .clk        (clk),
      .rst_i      (rst_i),
      .phase_i    (phase),
      .mem_we_i   (mem_we_o),
      .mem_addr_i (mem_addr_o),
      .pc_i       (pc)
   );

   assign mem_rdata = mem[mem_addr[7:0]]; // word addressed, same-cycle read

   always @(posedge clk)
   begin
      if (rst)
         mem <= image;
      else if (mem_we)
         mem[mem_addr[7:0]] <= mem_wdata;
   end

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout after %0d cycles, the tests did not finish", cycles);
         $display("test failed");
         $finish;
      end
   end

   function automatic logic [31:0] alu_word(input logic [3:0] cond, input logic imm,
      input logic [3:0] op, input logic [3:0] rd, input logic [3:0] ra,
      input logic [11:0] low);
      return {cond, 2'b00, imm, 1'b0, rd, ra, op, low};
   endfunction

   // the store data register is offset bits 11:8
   function automatic logic [31:0] mem_word(input logic st, input logic [3:0] rd,
      input logic [3:0] ra, input logic [15:0] off);
      return {4'h0, 2'b10, !st, 1'b0, rd, ra, off};
   endfunction

   function automatic logic [31:0] call_word(input logic [23:0] target);
      return {4'h0, 3'b010, 1'b0, target};
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic clear_image();
      for (int i = 0; i < 256; i++)
         image[i] = 32'h0600_0000 | i; // class 3 no-op tagged with its address
   endtask

   task automatic pulse_reset();
      rst = 1'b1;
      repeat (3) @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic run(input int n);
      repeat (4 * n) @(negedge clk);
   endtask

   // r15 goes first, before the next exec phase moves it
   task automatic snapshot();
      for (int i = 15; i >= 0; i--)
      begin
         test_rsel = 4'(i);
         #1;
         snap[i] = test_reg;
         @(negedge clk);
      end
   endtask

   task automatic alu_ops();
      logic [31:0] a, b;
      a = 32'h0000_0123;
      b = 32'hffff_fffb; // -5
      clear_image();
      image[0] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd1, 4'd0, 12'h123);
      image[1] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd2, 4'd0, 12'hffb);
      image[2] = alu_word(cpu_pkg::c_al, 1'b0, cpu_pkg::op_add, 4'd3, 4'd1, {4'd2, 8'h00});
      image[3] = alu_word(cpu_pkg::c_al, 1'b0, cpu_pkg::op_sub, 4'd4, 4'd1, {4'd2, 8'h00});
      image[4] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_and, 4'd5, 4'd1, 12'h0f0);
      image[5] = alu_word(cpu_pkg::c_al, 1'b0, cpu_pkg::op_or, 4'd6, 4'd1, {4'd2, 8'h00});
      image[6] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_xor, 4'd7, 4'd1, 12'h7ff);
      image[7] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_shl, 4'd8, 4'd1, 12'h004);
      image[8] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_shr, 4'd9, 4'd2, 12'h01c);
      image[9] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_add, 4'd10, 4'd1, 12'hfff);
      pulse_reset();
      run(10);
      snapshot();
      check("pc after alu ops", snap[15], 32'd10);
      check("mov imm", snap[1], a);
      check("mov negative imm", snap[2], b);
      check("add", snap[3], a + b);
      check("sub", snap[4], a - b);
      check("and imm", snap[5], a & 32'h0000_00f0);
      check("or", snap[6], a | b);
      check("xor imm", snap[7], a ^ 32'h0000_07ff);
      check("shl imm", snap[8], a << 4);
      check("shr imm", snap[9], b >> 28);
      check("add negative imm", snap[10], a + 32'hffff_ffff);
   endtask

   task automatic flag_conds();
      logic [31:0] p, q, m;
      p = 32'd7;
      q = 32'd7;
      m = 32'hffff_fffd; // -3
      clear_image();
      image[0] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd1, 4'd0, 12'h007);
      image[1] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd2, 4'd0, 12'h007);
      image[2] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd3, 4'd0, 12'hffd);
      image[3] = alu_word(cpu_pkg::c_al, 1'b0, cpu_pkg::op_cmp, 4'd4, 4'd1, {4'd2, 8'h00});
      image[4] = alu_word(cpu_pkg::c_eq, 1'b1, cpu_pkg::op_mov, 4'd5, 4'd0, 12'h001);
      image[5] = alu_word(cpu_pkg::c_ne, 1'b1, cpu_pkg::op_mov, 4'd6, 4'd0, 12'h001);
      image[6] = alu_word(cpu_pkg::c_cs, 1'b1, cpu_pkg::op_mov, 4'd7, 4'd0, 12'h001);
      image[7] = alu_word(cpu_pkg::c_al, 1'b0, cpu_pkg::op_cmp, 4'd4, 4'd3, {4'd1, 8'h00});
      image[8] = alu_word(cpu_pkg::c_lt, 1'b1, cpu_pkg::op_mov, 4'd8, 4'd0, 12'h001);
      image[9] = alu_word(cpu_pkg::c_gt, 1'b1, cpu_pkg::op_mov, 4'd9, 4'd0, 12'h001);
      image[10] = alu_word(cpu_pkg::c_hi, 1'b1, cpu_pkg::op_mov, 4'd10, 4'd0, 12'h001);
      image[11] = alu_word(cpu_pkg::c_ge, 1'b1, cpu_pkg::op_mov, 4'd11, 4'd0, 12'h001);
      image[12] = alu_word(cpu_pkg::c_al, 1'b0, cpu_pkg::op_cmp, 4'd4, 4'd1, {4'd3, 8'h00});
      image[13] = alu_word(cpu_pkg::c_gt, 1'b1, cpu_pkg::op_mov, 4'd12, 4'd0, 12'h001);
      image[14] = alu_word(cpu_pkg::c_cc, 1'b1, cpu_pkg::op_mov, 4'd13, 4'd0, 12'h001);
      pulse_reset();
      run(15);
      snapshot();
      check("pc after conditions", snap[15], 32'd15);
      check("cmp destination", snap[4], 32'd0);
      check("eq after 7 cmp 7", snap[5], {31'd0, p == q});
      check("ne after 7 cmp 7", snap[6], {31'd0, p != q});
      check("cs after 7 cmp 7", snap[7], {31'd0, p >= q}); // unsigned, no borrow
      check("lt after -3 cmp 7", snap[8], {31'd0, $signed(m) < $signed(p)});
      check("gt after -3 cmp 7", snap[9], {31'd0, $signed(m) > $signed(p)});
      check("hi after -3 cmp 7", snap[10], {31'd0, m > p}); // unsigned above
      check("ge after -3 cmp 7", snap[11], {31'd0, $signed(m) >= $signed(p)});
      check("gt after 7 cmp -3", snap[12], {31'd0, $signed(p) > $signed(m)});
      check("cc after 7 cmp -3", snap[13], {31'd0, p < m});
   endtask

   task automatic store_load();
      logic [31:0] base, data;
      base = 32'h0000_0020;
      data = 32'hffff_fa5b; // sign-extended 12'ha5b
      clear_image();
      image[0] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd1, 4'd0, 12'h020);
      image[1] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd0, 4'd0, 12'ha5b);
      image[2] = mem_word(1'b1, 4'd0, 4'd1, 16'h0040); // st r0
      image[3] = mem_word(1'b0, 4'd2, 4'd1, 16'h0040);
      image[4] = mem_word(1'b0, 4'd3, 4'd1, 16'hfff0); // 16 words below base
      pulse_reset();
      run(5);
      snapshot();
      check("pc after load/store", snap[15], 32'd5);
      check("stored word", mem[base[7:0] + 8'h40], data);
      check("loaded word", snap[2], data);
      check("load below base", snap[3], 32'h0600_0000 | (base - 32'd16));
   endtask

   task automatic branch_call();
      clear_image();
      image[0] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd15, 4'd0, 12'h004);
      image[1] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd1, 4'd0, 12'h001);
      image[2] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd2, 4'd0, 12'h002);
      image[4] = call_word(24'h00_0010);
      image[5] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd3, 4'd0, 12'h003);
      image[16] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd4, 4'd0, 12'h004);
      image[17] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd5, 4'd0, 12'h005);
      pulse_reset();
      run(4); // jump, call and the two moves at the target
      snapshot();
      check("pc after call", snap[15], 32'h0000_0012);
      check("link register", snap[14], 32'd4 + 32'd1);
      check("skipped r1", snap[1], 32'd0);
      check("skipped r2", snap[2], 32'd0);
      check("skipped r3", snap[3], 32'd0);
      check("target r4", snap[4], 32'd4);
      check("target r5", snap[5], 32'd5);
   endtask

   task automatic mid_reset();
      clear_image();
      image[0] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd1, 4'd0, 12'h055);
      image[1] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd2, 4'd0, 12'h066);
      image[2] = alu_word(cpu_pkg::c_al, 1'b1, cpu_pkg::op_mov, 4'd3, 4'd0, 12'h077);
      pulse_reset();
      run(2);
      repeat (2) @(negedge clk); // halfway into the third instruction
      rst = 1'b1;
      repeat (3) @(negedge clk);
      snapshot(); // reset still held
      for (int i = 0; i < 16; i++)
         check($sformatf("r%0d in reset", i), snap[i], 32'd0);
      rst = 1'b0;
      run(1);
      // second instruction is only being fetched here
      test_rsel = 4'd2;
      #1;
      check("r2 after restart", test_reg, 32'd0);
      @(negedge clk);
      snapshot();
      check("pc after restart", snap[15], 32'd1);
      check("first instruction again", snap[1], 32'h0000_0055);
   endtask

   initial
   begin
      rst = 1'b1;
      test_rsel = 4'd0;
      @(negedge clk);
      alu_ops();
      flag_conds();
      store_load();
      branch_call();
      mid_reset();
      $display("checks done, %0d errors", errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// File: list.f
common/cpu_pkg.sv
hdl/phase_sched.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/cpu_core.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim \
   || { echo "build failed"; exit 1; }
out="$(./obj_dir/cpu_sim 2>&1)"
echo "$out"
grep -qx "test passed" <<< "$out" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
